/* bench/snake_core_tb.sv */
`timescale 1ns/1ps

module snake_core_tb;

    localparam int STEP_TIMEOUT = 64;

    logic            clk;
    logic            rst_n;
    logic            button_up;
    logic            button_down;
    logic            button_left;
    logic            button_right;
    logic            button_start;
    logic [3:0]      x;
    logic [3:0]      y;
    logic            apple;
    logic            body;
    logic            head;
    logic            gameover;
    logic [1:0]      game_state;
    logic [7:0]      score;
    logic [3:0]      head_x;
    logic [3:0]      head_y;

    // fields of one test line
    logic [8*32-1:0] test_name;
    logic [8*16-1:0] cmd;
    logic [8*16-1:0] arg;
    logic [8*16-1:0] exp_state;
    logic [8*128-1:0] line_rest;
    int              exp_hx;
    int              exp_hy;
    int              exp_score;
    int              exp_cells;
    int              exp_ax;
    int              exp_ay;
    int              exp_period;

    // results of the last grid scan
    int              snake_cells;
    int              head_cells;
    int              apple_cells;
    int              overlap_cells;
    int              apple_x;
    int              apple_y;
    int              flag_hx;
    int              flag_hy;

    int              last_period;
    int              test_errors;
    int              error_count;
    int              fail_tests;
    int              test_count;
    int              fd;
    int              r;
    logic            timed_out;
    logic            file_error;
    logic            done;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    snake_core i_snake_core (
        .clk(clk), .rst_n(rst_n),
        .button_up(button_up), .button_down(button_down), .button_left(button_left),
        .button_right(button_right), .button_start(button_start),
        .x(x), .y(y), .apple(apple), .body(body), .head(head), .gameover(gameover),
        .game_state(game_state), .score(score), .head_x(head_x), .head_y(head_y)
    );

    // state name to its encoding and -1 for a state that is not checked
    function automatic int state_code(input logic [8*16-1:0] name);
        case (name)
            "WAIT":     return 0;
            "RUN":      return 1;
            "PAUSE":    return 2;
            "END_GAME": return 3;
            default:    return -1;
        endcase
    endfunction

    function automatic int parse_count(input logic [8*16-1:0] text);
        int         value;
        logic [7:0] c;
        value = 0;
        for (int i = 15; i >= 0; i--) begin
            c = text[i*8 +: 8];
            if (c >= "0" && c <= "9") value = value * 10 + (c - "0");
        end
        return value;
    endfunction

    task automatic check_value(input string label, input int expected, input int actual);
        if (expected >= 0 && expected != actual) begin
            $display("Error %0s: %0s expected %0d, actual %0d",
                     test_name, label, expected, actual);
            test_errors++;
        end
    endtask

    task automatic drive_button(input logic [8*16-1:0] name, input logic level);
        case (name)
            "up":    button_up    <= level;
            "down":  button_down  <= level;
            "left":  button_left  <= level;
            "right": button_right <= level;
            "start": button_start <= level;
            default: begin
                $display("%0s: unknown button name %0s", test_name, name);
                test_errors++;
            end
        endcase
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    // the press pulse shows up 3 cycles after the raw edge and acts one cycle later
    task automatic press_button(input logic [8*16-1:0] name);
        @(posedge clk);
        drive_button(name, 1'b1);
        repeat (2) @(posedge clk);
        drive_button(name, 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_steps(input int count);
        logic [7:0] last_head;
        int         cycles;
        for (int k = 0; k < count; k++) begin
            last_head = {head_y, head_x};
            cycles = 0;
            while ({head_y, head_x} == last_head && cycles < STEP_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if ({head_y, head_x} == last_head) begin
                $display("%0s: timeout, the head did not move within %0d cycles",
                         test_name, STEP_TIMEOUT);
                timed_out = 1'b1;
                return;
            end
            if (k > 0) last_period = cycles;
        end
        // collision pulse and score follow the head by two cycles
        repeat (2) @(negedge clk);
    endtask

    task automatic hold_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic scan_grid();
        snake_cells   = 0;
        head_cells    = 0;
        apple_cells   = 0;
        overlap_cells = 0;
        apple_x       = -1;
        apple_y       = -1;
        flag_hx       = -1;
        flag_hy       = -1;
        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            x <= i[3:0];
            y <= i[7:4];
            @(negedge clk);
            if (head || body) snake_cells++;
            if (head) begin
                head_cells++;
                flag_hx = i % 16;
                flag_hy = i / 16;
            end
            if (apple) begin
                apple_cells++;
                apple_x = i % 16;
                apple_y = i / 16;
            end
            if (apple && (head || body)) overlap_cells++;
        end
    endtask

    task automatic check_results();
        int st;
        st = state_code(exp_state);
        check_value("state", st, game_state);
        if (st >= 0) check_value("gameover", (st == 3) ? 1 : 0, gameover);
        check_value("head x", exp_hx, head_x);
        check_value("head y", exp_hy, head_y);
        check_value("score", exp_score, score);
        check_value("step period", exp_period, last_period);
        if (cmd == "scan") begin
            check_value("snake cells", exp_cells, snake_cells);
            check_value("head cells", 1, head_cells);
            check_value("head flag x", exp_hx, flag_hx);
            check_value("head flag y", exp_hy, flag_hy);
            check_value("apple cells", 1, apple_cells);
            check_value("apple on snake", 0, overlap_cells);
            check_value("apple x", exp_ax, apple_x);
            check_value("apple y", exp_ay, apple_y);
        end
    endtask

    task automatic run_test();
        test_errors = 0;
        last_period = -1;
        case (cmd)
            "reset": apply_reset();
            "press": press_button(arg);
            "steps": wait_steps(parse_count(arg));
            "hold":  hold_cycles(parse_count(arg));
            "scan":  scan_grid();
            default: begin
                $display("%0s: unknown command %0s", test_name, cmd);
                test_errors++;
            end
        endcase
        if (timed_out) begin
            test_errors++;
        end else begin
            check_results();
        end
        test_count++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("%0s: ok", test_name);
        end else begin
            fail_tests++;
            $display("%0s: %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        button_up    = 1'b0;
        button_down  = 1'b0;
        button_left  = 1'b0;
        button_right = 1'b0;
        button_start = 1'b0;
        x            = 4'd0;
        y            = 4'd0;
        timed_out    = 1'b0;
        file_error   = 1'b0;
        done         = 1'b0;
        test_count   = 0;
        fail_tests   = 0;
        error_count  = 0;

        fd = $fopen("bench/snake_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/snake_tests.txt");
            file_error = 1'b1;
            done = 1'b1;
        end
        while (!done && !timed_out) begin
            r = $fscanf(fd, "%s", test_name);
            if (r != 1) begin
                done = 1'b1;
            end else if (test_name == "#") begin
                r = $fgets(line_rest, fd);
            end else begin
                r = $fscanf(fd, "%s %s %s %d %d %d %d %d %d %d", cmd, arg, exp_state,
                            exp_hx, exp_hy, exp_score, exp_cells, exp_ax, exp_ay, exp_period);
                if (r != 10) begin
                    $display("%0s: the test line is incomplete", test_name);
                    file_error = 1'b1;
                    done = 1'b1;
                end else begin
                    run_test();
                end
            end
        end
        if (fd != 0) $fclose(fd);

        $display("tests: %0d, failing tests: %0d, failed checks: %0d",
                 test_count, fail_tests, error_count);
        if (fail_tests == 0 && !timed_out && !file_error && test_count > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* bench/snake_tests.txt */
# name command arg state head_x head_y score snake_cells apple_x apple_y step_period
# a - or -1 marks a value that is not checked
reset_init     reset  -      WAIT      4  8  0  -1  -1  -1  -1
reset_scan     scan   -      WAIT      4  8  0   3   7   8  -1
start_game     press  start  RUN       4  8  0  -1  -1  -1  -1
eat_apple      steps  3      RUN       7  8  1  -1  -1  -1   8
turn_up        press  up     RUN       7  8  1  -1  -1  -1  -1
move_up        steps  2      RUN       7  6  1  -1  -1  -1   8
reverse_down   press  down   RUN       7  6  1  -1  -1  -1  -1
keep_up        steps  1      RUN       7  5  1  -1  -1  -1  -1
pause_game     press  start  PAUSE     7  5  1  -1  -1  -1  -1
pause_scan     scan   -      PAUSE     7  5  1   4  -1  -1  -1
pause_hold     hold   40     PAUSE     7  5  1  -1  -1  -1  -1
resume_game    press  start  RUN       7  5  1  -1  -1  -1  -1
reach_top      steps  5      RUN       7  0  1  -1  -1  -1   8
hit_border     hold   12     END_GAME  7  0  1  -1  -1  -1  -1
restart_game   press  start  WAIT      4  8  0  -1  -1  -1  -1
restart_scan   scan   -      WAIT      4  8  0   3   7   8  -1
select_fast    press  up     WAIT      4  8  0  -1  -1  -1  -1
start_fast     press  start  RUN       4  8  0  -1  -1  -1  -1
fast_steps     steps  2      RUN       6  8  0  -1  -1  -1   4

/* design/apple_gen.sv */
`timescale 1ns/1ps
`include "snake_params.svh"

module apple_gen (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            restart,
    input  logic                                            apple_hit,
    input  snake_pkg::grid_cell_u [`SNAKE_MAX_LENGTH-1:0]   body,
    input  logic [4:0]                                      length,
    output snake_pkg::grid_cell_u                           apple,
    output logic                                            apple_valid
);

    import snake_pkg::*;

    logic [7:0] lfsr;
    logic [7:0] lfsr_next;
    logic       searching;
    logic       on_body;
    grid_cell_u candidate;

    // x^8 + x^6 + x^5 + x^4 + 1, never reaches zero from a nonzero seed
    assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

    assign candidate.index = lfsr;

    always_comb begin
        on_body = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LENGTH; i++) begin
            if (i < length && body[i].index == candidate.index) on_body = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr        <= `LFSR_SEED;
            apple.index <= {4'(`APPLE_START_Y), 4'(`APPLE_START_X)};
            searching   <= 1'b0;
        end else if (restart) begin
            apple.index <= {4'(`APPLE_START_Y), 4'(`APPLE_START_X)};
            searching   <= 1'b0;
        end else if (apple_hit) begin
            searching <= 1'b1;
            lfsr      <= lfsr_next;
        end else if (searching) begin
            if (on_body) begin
                lfsr <= lfsr_next;
            end else begin
                apple     <= candidate;
                searching <= 1'b0;
            end
        end
    end

    assign apple_valid = ~searching;

endmodule

/* design/button_sync.sv */
`timescale 1ns/1ps

module button_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic button,
    output logic press
);

    logic sync_meta;
    logic sync_out;
    logic sync_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta <= 1'b0;
            sync_out  <= 1'b0;
            sync_last <= 1'b0;
        end else begin
            sync_meta <= button;
            sync_out  <= sync_meta;
            sync_last <= sync_out;
        end
    end

    // rising edge of the synchronized level
    assign press = sync_out & ~sync_last;

endmodule

/* design/collision_check.sv */
`timescale 1ns/1ps
`include "snake_params.svh"

module collision_check (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            step,
    input  snake_pkg::grid_cell_u                           head,
    input  snake_pkg::grid_cell_u                           next_head,
    input  logic                                            edge_out,
    input  snake_pkg::grid_cell_u [`SNAKE_MAX_LENGTH-1:0]   body,
    input  logic [4:0]                                      length,
    input  snake_pkg::grid_cell_u                           apple,
    output logic                                            bad_hit,
    output logic                                            apple_hit
);

    import snake_pkg::*;

    logic       step_d;
    logic       border_d;
    logic       self_hit;
    grid_cell_u target;

    // target of the last step, equal to the head once the move has happened
    always_ff @(posedge clk) begin
        if (step) target <= next_head;
    end

    // segment 0 is the head itself
    always_comb begin
        self_hit = 1'b0;
        for (int i = 1; i < `SNAKE_MAX_LENGTH; i++) begin
            if (i < length && body[i].xy == head.xy) self_hit = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_d    <= 1'b0;
            border_d  <= 1'b0;
            bad_hit   <= 1'b0;
            apple_hit <= 1'b0;
        end else begin
            step_d    <= step;
            border_d  <= step & edge_out;
            bad_hit   <= step_d & (border_d | self_hit);
            apple_hit <= step_d & ~border_d & (target.xy == apple.xy);
        end
    end

endmodule

/* design/game_fsm.sv */
`timescale 1ns/1ps

module game_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_press,
    input  logic                    up_press,
    input  logic                    bad_hit,
    output snake_pkg::game_state_e  game_state,
    output snake_pkg::game_speed_e  game_speed,
    output logic                    restart
);

    import snake_pkg::*;

    game_state_e next_state;

    always_comb begin
        next_state = game_state;
        case (game_state)
            WAIT: begin
                if (start_press) next_state = RUN;
            end
            RUN: begin
                // a crash wins over a pause on the same cycle
                if (bad_hit) begin
                    next_state = END_GAME;
                end else if (start_press) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (start_press) next_state = RUN;
            end
            END_GAME: begin
                if (start_press) next_state = WAIT;
            end
            default: next_state = WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_state <= WAIT;
        end else begin
            game_state <= next_state;
        end
    end

    // speed select cycles normal -> fast -> slow, only while waiting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_speed <= NORMAL_SPEED;
        end else if (game_state == WAIT && up_press) begin
            case (game_speed)
                NORMAL_SPEED: game_speed <= FAST_SPEED;
                FAST_SPEED:   game_speed <= SLOW_SPEED;
                default:      game_speed <= NORMAL_SPEED;
            endcase
        end
    end

    assign restart = (game_state == END_GAME) && start_press;

endmodule

/* design/snake_body.sv */
`timescale 1ns/1ps
`include "snake_params.svh"

module snake_body (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            restart,
    input  logic                                            step,
    input  logic                                            up_press,
    input  logic                                            down_press,
    input  logic                                            left_press,
    input  logic                                            right_press,
    input  logic                                            apple_hit,
    input  snake_pkg::game_state_e                          game_state,
    output snake_pkg::grid_cell_u                           head,
    output snake_pkg::grid_cell_u                           next_head,
    output logic                                            edge_out,
    output snake_pkg::grid_cell_u [`SNAKE_MAX_LENGTH-1:0]   body,
    output logic [4:0]                                      length,
    output logic [7:0]                                      score
);

    import snake_pkg::*;

    direction_e dir;
    direction_e pending_dir;
    direction_e press_dir;
    logic       press_valid;

    // head at segment 0, the rest trails to the left and parks on the last start cell
    function automatic grid_cell_u [`SNAKE_MAX_LENGTH-1:0] start_body();
        grid_cell_u [`SNAKE_MAX_LENGTH-1:0] cells;
        for (int i = 0; i < `SNAKE_MAX_LENGTH; i++) begin
            cells[i].xy.y = 4'(`SNAKE_START_HEAD_Y);
            if (i < `SNAKE_START_LENGTH) begin
                cells[i].xy.x = 4'(`SNAKE_START_HEAD_X - i);
            end else begin
                cells[i].xy.x = 4'(`SNAKE_START_HEAD_X - `SNAKE_START_LENGTH + 1);
            end
        end
        return cells;
    endfunction

    always_comb begin
        press_valid = 1'b1;
        press_dir   = pending_dir;
        if (up_press) begin
            press_dir = UP;
        end else if (down_press) begin
            press_dir = DOWN;
        end else if (left_press) begin
            press_dir = LEFT;
        end else if (right_press) begin
            press_dir = RIGHT;
        end else begin
            press_valid = 1'b0;
        end
    end

    assign head = body[0];

    always_comb begin
        next_head = head;
        edge_out  = 1'b0;
        case (pending_dir)
            UP: begin
                edge_out       = (head.xy.y == 4'd0);
                next_head.xy.y = head.xy.y - 4'd1;
            end
            DOWN: begin
                edge_out       = (head.xy.y == 4'(`GRID_SIZE - 1));
                next_head.xy.y = head.xy.y + 4'd1;
            end
            LEFT: begin
                edge_out       = (head.xy.x == 4'd0);
                next_head.xy.x = head.xy.x - 4'd1;
            end
            default: begin
                edge_out       = (head.xy.x == 4'(`GRID_SIZE - 1));
                next_head.xy.x = head.xy.x + 4'd1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dir         <= RIGHT;
            pending_dir <= RIGHT;
            body        <= start_body();
            length      <= 5'(`SNAKE_START_LENGTH);
            score       <= 8'd0;
        end else if (restart) begin
            dir         <= RIGHT;
            pending_dir <= RIGHT;
            body        <= start_body();
            length      <= 5'(`SNAKE_START_LENGTH);
            score       <= 8'd0;
        end else begin
            // reversal test: opposite directions differ only in bit 0
            if (game_state == RUN && press_valid && press_dir != direction_e'(dir ^ 2'b01)) begin
                pending_dir <= press_dir;
            end
            // an outward move at the border is left to the collision check
            if (step && !edge_out) begin
                dir     <= pending_dir;
                body    <= {body[`SNAKE_MAX_LENGTH-2:0], next_head};
            end
            if (apple_hit) begin
                if (length < 5'(`SNAKE_MAX_LENGTH)) length <= length + 5'd1;
                score <= score + 8'd1;
            end
        end
    end

endmodule

/* design/snake_core.sv */
`timescale 1ns/1ps
`include "snake_params.svh"

module snake_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    button_up,
    input  logic                    button_down,
    input  logic                    button_left,
    input  logic                    button_right,
    input  logic                    button_start,
    input  logic [3:0]              x,
    input  logic [3:0]              y,
    output logic                    apple,
    output logic                    body,
    output logic                    head,
    output logic                    gameover,
    output snake_pkg::game_state_e  game_state,
    output logic [7:0]              score,
    output logic [3:0]              head_x,
    output logic [3:0]              head_y
);

    import snake_pkg::*;

    logic        up_press, down_press, left_press, right_press, start_press;
    logic        restart, step, edge_out, bad_hit, apple_hit, apple_valid;
    logic [4:0]  length;
    game_speed_e game_speed;
    grid_cell_u  head_cell, next_head, apple_cell, query;
    grid_cell_u [`SNAKE_MAX_LENGTH-1:0] body_cells;

    button_sync sync_up    (.clk(clk), .rst_n(rst_n), .button(button_up),    .press(up_press));
    button_sync sync_down  (.clk(clk), .rst_n(rst_n), .button(button_down),  .press(down_press));
    button_sync sync_left  (.clk(clk), .rst_n(rst_n), .button(button_left),  .press(left_press));
    button_sync sync_right (.clk(clk), .rst_n(rst_n), .button(button_right), .press(right_press));
    button_sync sync_start (.clk(clk), .rst_n(rst_n), .button(button_start), .press(start_press));

    game_fsm i_game_fsm (
        .clk(clk), .rst_n(rst_n), .start_press(start_press), .up_press(up_press),
        .bad_hit(bad_hit), .game_state(game_state), .game_speed(game_speed), .restart(restart)
    );

    step_timer i_step_timer (
        .clk(clk), .rst_n(rst_n), .game_state(game_state), .game_speed(game_speed), .step(step)
    );

    snake_body i_snake_body (
        .clk(clk), .rst_n(rst_n), .restart(restart), .step(step),
        .up_press(up_press), .down_press(down_press),
        .left_press(left_press), .right_press(right_press),
        .apple_hit(apple_hit), .game_state(game_state),
        .head(head_cell), .next_head(next_head), .edge_out(edge_out),
        .body(body_cells), .length(length), .score(score)
    );

    apple_gen i_apple_gen (
        .clk(clk), .rst_n(rst_n), .restart(restart), .apple_hit(apple_hit),
        .body(body_cells), .length(length), .apple(apple_cell), .apple_valid(apple_valid)
    );

    collision_check i_collision_check (
        .clk(clk), .rst_n(rst_n), .step(step), .head(head_cell), .next_head(next_head),
        .edge_out(edge_out), .body(body_cells), .length(length), .apple(apple_cell),
        .bad_hit(bad_hit), .apple_hit(apple_hit)
    );

    // pixel query, the apple stays hidden while a new one is being placed
    assign query.index = {y, x};
    assign apple = apple_valid && (apple_cell.index == query.index);
    assign head  = (head_cell.index == query.index);

    always_comb begin
        body = 1'b0;
        for (int i = 1; i < `SNAKE_MAX_LENGTH; i++) begin
            if (i < length && body_cells[i].index == query.index) body = 1'b1;
        end
    end

    assign gameover = (game_state == END_GAME);
    assign head_x   = head_cell.xy.x;
    assign head_y   = head_cell.xy.y;

endmodule

/* design/snake_params.svh */
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

`define GRID_SIZE           16

`define SNAKE_MAX_LENGTH    16
`define SNAKE_START_LENGTH  3
`define SNAKE_START_HEAD_X  4
`define SNAKE_START_HEAD_Y  8

`define APPLE_START_X       7
`define APPLE_START_Y       8

// step periods in clock cycles
`define STEP_NORMAL         8
`define STEP_FAST           4
`define STEP_SLOW           16

`define LFSR_SEED           8'hA5

`endif

/* design/snake_pkg.sv */
package snake_pkg;

    typedef enum logic [1:0] {
        WAIT     = 2'b00,
        RUN      = 2'b01,
        PAUSE    = 2'b10,
        END_GAME = 2'b11
    } game_state_e;

    // UP decrements y, DOWN increments it
    typedef enum logic [1:0] {
        UP    = 2'b00,
        DOWN  = 2'b01,
        LEFT  = 2'b10,
        RIGHT = 2'b11
    } direction_e;

    typedef enum logic [1:0] {
        NORMAL_SPEED = 2'b00,
        FAST_SPEED   = 2'b01,
        SLOW_SPEED   = 2'b10
    } game_speed_e;

    typedef struct packed {
        logic [3:0] y;
        logic [3:0] x;
    } grid_xy_t;

    // one grid cell, seen as coordinates or as a linear index {y, x}
    typedef union packed {
        grid_xy_t   xy;
        logic [7:0] index;
    } grid_cell_u;

endpackage

/* design/step_timer.sv */
`timescale 1ns/1ps
`include "snake_params.svh"

module step_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  snake_pkg::game_state_e  game_state,
    input  snake_pkg::game_speed_e  game_speed,
    output logic                    step
);

    import snake_pkg::*;

    logic [4:0] period;
    logic [4:0] count;

    always_comb begin
        case (game_speed)
            FAST_SPEED: period = 5'(`STEP_FAST);
            SLOW_SPEED: period = 5'(`STEP_SLOW);
            default:    period = 5'(`STEP_NORMAL);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= 5'd0;
            step  <= 1'b0;
        end else begin
            step <= 1'b0;
            if (game_state == RUN) begin
                if (count == 5'd0) begin
                    step  <= 1'b1;
                    count <= period - 5'd1;
                end else begin
                    count <= count - 5'd1;
                end
            end else if (game_state != PAUSE) begin
                // preload so the first step lands one full period after RUN starts
                count <= period - 5'd1;
            end
        end
    end

endmodule

/* snake_core.f */
+incdir+design
design/snake_pkg.sv
design/button_sync.sv
design/game_fsm.sv
design/step_timer.sv
design/snake_body.sv
design/apple_gen.sv
design/collision_check.sv
design/snake_core.sv
bench/snake_core_tb.sv
